// File: logic/slcPkg.sv
package slcPkg;

    // datapath widths
    typedef logic [15:0] word_t;    // bus, registers, memory data
    typedef logic [7:0]  memAddr_t; // low byte of MAR, 256 words
    typedef logic [2:0]  regIdx_t;  // register file index
    typedef logic [3:0]  busSrc_t;  // one-hot: MARMUX, PC, ALU, MDR
    typedef logic [1:0]  aluOp_t;   // ALU function select

    // bus drivers, one bit each
    localparam busSrc_t busMarmux = 4'b1000;
    localparam busSrc_t busPc     = 4'b0100;
    localparam busSrc_t busAlu    = 4'b0010;
    localparam busSrc_t busMdr    = 4'b0001;

    // IR[15:12] opcodes, LC-3 encoding
    localparam logic [3:0] opBr   = 4'b0000;
    localparam logic [3:0] opAdd  = 4'b0001;
    localparam logic [3:0] opAnd  = 4'b0101;
    localparam logic [3:0] opLdr  = 4'b0110;
    localparam logic [3:0] opStr  = 4'b0111;
    localparam logic [3:0] opNot  = 4'b1001;
    localparam logic [3:0] opTrap = 4'b1111;

    localparam logic [7:0] trapHalt = 8'h25; // TRAP x25 stops the core

    // ALU functions
    localparam aluOp_t aluAdd  = 2'd0;
    localparam aluOp_t aluAnd  = 2'd1;
    localparam aluOp_t aluNot  = 2'd2;
    localparam aluOp_t aluPass = 2'd3; // SR1 straight through, base for LDR/STR

    // memory and reset
    localparam int    memDepth = 256;
    localparam word_t pcReset  = 16'h0000;

endpackage

// File: logic/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import slcPkg::*;

    logic    ldPc, ldMar, ldMdr, ldIr, ldReg, ldCc; // load strobes
    busSrc_t busSrc;    // one-hot bus gate
    logic    pcSel;     // 0 = PC+1, 1 = address adder
    logic    mdrSel;    // 0 = bus, 1 = memory read data
    aluOp_t  aluOp;
    logic    sr2Imm;    // second operand is imm5
    logic    offsetSel; // 1 = PC + offset9, 0 = base + offset6
    logic    memReq, memWe;
    word_t   ir;        // status back from the datapath
    logic    ben;       // branch taken

    modport controller (
        output ldPc, ldMar, ldMdr, ldIr, ldReg, ldCc, busSrc, pcSel, mdrSel,
        output aluOp, sr2Imm, offsetSel, memReq, memWe,
        input  ir, ben
    );

    modport datapath (
        input  ldPc, ldMar, ldMdr, ldIr, ldReg, ldCc, busSrc, pcSel, mdrSel,
        input  aluOp, sr2Imm, offsetSel, memReq, memWe,
        output ir, ben
    );

endinterface

// File: logic/memIf.sv
`timescale 1ns/1ps

interface memIf;
    import slcPkg::*;

    logic     req;   // held until gnt
    logic     we;
    memAddr_t addr;
    word_t    wdata;
    logic     gnt;   // access happens this cycle
    word_t    rdata; // valid the cycle after a read gnt

    modport datapath (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport memory (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// File: logic/pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          ldPc,
    input  logic          pcSel,  // 1 takes the branch target
    input  slcPkg::word_t target,
    output slcPkg::word_t pc
);
    import slcPkg::*;

    word_t pcNext;

    // PCMUX
    always_comb
    begin
        if (pcSel)
            pcNext = target;       // taken branch
        else
            pcNext = pc + 16'd1;   // sequential fetch
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            pc <= pcReset;
        else if (ldPc)
            pc <= pcNext;
    end

    // an X select would silently corrupt the PC
    pcSelKnown: assert property (@(posedge Clk) disable iff (!rstN)
        ldPc |-> !$isunknown(pcSel));

endmodule

// File: logic/marMdr.sv
`timescale 1ns/1ps

module marMdr (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          ldMar,
    input  logic          ldMdr,
    input  logic          mdrSel,  // 1 = memory, 0 = bus
    input  logic          memReq,
    input  logic          memWe,
    input  slcPkg::word_t bus,
    memIf.datapath        mem,
    output slcPkg::word_t mdr
);
    import slcPkg::*;

    word_t mar;
    word_t mdrNext;

    // MAR low byte is the memory address
    always_ff @(posedge Clk)
    begin
        if (!rstN)
            mar <= '0;
        else if (ldMar)
            mar <= bus;
    end

    assign mdrNext = mdrSel ? mem.rdata : bus; // MDRMUX

    always_ff @(posedge Clk)
    begin
        if (ldMdr)
            mdr <= mdrNext;
    end

    // core side of the memory port
    assign mem.addr  = mar[7:0]; // only 256 words exist
    assign mem.wdata = mdr;
    assign mem.req   = memReq;
    assign mem.we    = memWe;

endmodule

// File: logic/regFileAlu.sv
`timescale 1ns/1ps

module regFileAlu (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             ldReg,
    input  logic             ldCc,
    input  slcPkg::regIdx_t  dr,
    input  slcPkg::regIdx_t  sr1,
    input  slcPkg::regIdx_t  sr2,
    input  logic             sr2Imm,
    input  slcPkg::aluOp_t   aluOp,
    input  slcPkg::word_t    imm5,    // already sign-extended
    input  slcPkg::word_t    bus,
    output slcPkg::word_t    aluOut,
    output logic [2:0]       nzp
);
    import slcPkg::*;

    word_t regs [8]; // R0..R7
    word_t opA;
    word_t opB;

    // register writes come from the bus only
    always_ff @(posedge Clk)
    begin
        if (ldReg)
            regs[dr] <= bus;
    end

    assign opA = regs[sr1];
    assign opB = sr2Imm ? imm5 : regs[sr2]; // SR2MUX

    always_comb
    begin
        unique case (aluOp)
            aluAdd:  aluOut = opA + opB; // wraps at 16 bits
            aluAnd:  aluOut = opA & opB;
            aluNot:  aluOut = ~opA;
            default: aluOut = opA;       // pass for the LDR/STR base address
        endcase
    end

    // condition codes follow whatever lands in a register
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            nzp <= 3'b010; // z after reset
        end
        else if (ldCc)
        begin
            if (bus[15])
                nzp <= 3'b100;
            else if (bus == '0)
                nzp <= 3'b010;
            else
                nzp <= 3'b001;
        end
    end

    // an undefined bus value would quietly set p
    ccFromKnownBus: assert property (@(posedge Clk) disable iff (!rstN)
        ldCc |-> !$isunknown(bus));

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic          Clk,
    input  logic          rstN,
    ctrlIf.datapath       ctrl,
    memIf.datapath        mem,
    output slcPkg::word_t pcOut,
    output slcPkg::word_t irOut
);
    import slcPkg::*;

    word_t      bus;
    word_t      pc, mdr, aluOut, addrSum, ir;
    word_t      offset9, offset6, imm5;
    regIdx_t    sr1;
    logic [2:0] nzp;

    // sign-extended IR fields
    assign offset9 = {{7{ir[8]}}, ir[8:0]};
    assign offset6 = {{10{ir[5]}}, ir[5:0]};
    assign imm5    = {{11{ir[4]}}, ir[4:0]};

    // address adder, PC-relative for BR and base-relative for LDR/STR
    assign addrSum = ctrl.offsetSel ? pc + offset9 : aluOut + offset6;

    // STR moves its source reg to MDR through the ALU pass path
    assign sr1 = (ir[15:12] == opStr && ctrl.busSrc == busAlu) ? ir[11:9] : ir[8:6];

    always_comb
    begin
        unique case (ctrl.busSrc)
            busMarmux: bus = addrSum;
            busPc:     bus = pc;
            busAlu:    bus = aluOut;
            busMdr:    bus = mdr;
            default:   bus = '0; // nothing gated
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            ir <= '0;
        else if (ctrl.ldIr)
            ir <= bus;
    end

    assign ctrl.ir  = ir;
    assign ctrl.ben = |(ir[11:9] & nzp); // any requested flag set
    assign pcOut    = pc;
    assign irOut    = ir;

    pcUnit pcUnit_i (.Clk(Clk), .rstN(rstN), .ldPc(ctrl.ldPc), .pcSel(ctrl.pcSel),
                     .target(addrSum), .pc(pc));

    marMdr marMdr_i (.Clk(Clk), .rstN(rstN), .ldMar(ctrl.ldMar), .ldMdr(ctrl.ldMdr),
                     .mdrSel(ctrl.mdrSel), .memReq(ctrl.memReq), .memWe(ctrl.memWe),
                     .bus(bus), .mem(mem), .mdr(mdr));

    regFileAlu regFileAlu_i (.Clk(Clk), .rstN(rstN), .ldReg(ctrl.ldReg), .ldCc(ctrl.ldCc),
                             .dr(ir[11:9]), .sr1(sr1), .sr2(ir[2:0]), .sr2Imm(ctrl.sr2Imm),
                             .aluOp(ctrl.aluOp), .imm5(imm5), .bus(bus),
                             .aluOut(aluOut), .nzp(nzp));

    // bus contention check, the FSM gates at most one driver
    busOneHot: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0(ctrl.busSrc));

endmodule

// File: logic/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
    input  logic       Clk,
    input  logic       rstN,
    input  logic       run,
    ctrlIf.controller  ctrl,
    input  logic       gnt,
    output logic       halted
);
    import slcPkg::*;

    typedef enum logic [3:0] {
        sIdle, sFetch1, sFetch2, sFetch3, sFetch4, sDecode,
        sAlu, sBr,
        sLdrAddr, sLdrRead, sLdrCap, sLdrWb,
        sStrAddr, sStrData, sStrWrite,
        sHalt
    } state_t;

    state_t     state, stateNext;
    logic [3:0] opcode;

    assign opcode = ctrl.ir[15:12];

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            state <= sIdle;
        else
            state <= stateNext;
    end

    always_comb
    begin
        stateNext = state;
        unique case (state)
            sIdle:    if (run) stateNext = sFetch1;
            sFetch1:  stateNext = sFetch2;
            sFetch2:  if (gnt) stateNext = sFetch3; // hold read until granted
            sFetch3:  stateNext = sFetch4;
            sFetch4:  stateNext = sDecode;
            sDecode:
            begin
                case (opcode)
                    opAdd, opAnd, opNot: stateNext = sAlu;
                    opBr:                stateNext = sBr;
                    opLdr:               stateNext = sLdrAddr;
                    opStr:               stateNext = sStrAddr;
                    opTrap:              stateNext = (ctrl.ir[7:0] == trapHalt) ? sHalt : sFetch1;
                    default:             stateNext = sFetch1; // unsupported, skip it
                endcase
            end
            sAlu, sBr: stateNext = sFetch1;
            sLdrAddr:  stateNext = sLdrRead;
            sLdrRead:  if (gnt) stateNext = sLdrCap;
            sLdrCap:   stateNext = sLdrWb;
            sLdrWb:    stateNext = sFetch1;
            sStrAddr:  stateNext = sStrData;
            sStrData:  stateNext = sStrWrite;
            sStrWrite: if (gnt) stateNext = sFetch1;
            sHalt:     stateNext = sHalt; // only reset leaves
            default:   stateNext = sIdle;
        endcase
    end

    always_comb
    begin
        ctrl.ldPc      = 1'b0;
        ctrl.ldMar     = 1'b0;
        ctrl.ldMdr     = 1'b0;
        ctrl.ldIr      = 1'b0;
        ctrl.ldReg     = 1'b0;
        ctrl.ldCc      = 1'b0;
        ctrl.busSrc    = '0;
        ctrl.pcSel     = 1'b0;
        ctrl.mdrSel    = 1'b0;
        ctrl.aluOp     = aluPass;
        ctrl.sr2Imm    = 1'b0;
        ctrl.offsetSel = 1'b0;
        ctrl.memReq    = 1'b0;
        ctrl.memWe     = 1'b0;
        unique case (state)
            sFetch1:
            begin
                ctrl.busSrc = busPc; // MAR <- PC, PC <- PC+1
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
            end
            sFetch2, sLdrRead: ctrl.memReq = 1'b1;
            sFetch3, sLdrCap:
            begin
                ctrl.mdrSel = 1'b1; // MDR <- rdata
                ctrl.ldMdr  = 1'b1;
            end
            sFetch4:
            begin
                ctrl.busSrc = busMdr;
                ctrl.ldIr   = 1'b1;
            end
            sAlu:
            begin
                ctrl.busSrc = busAlu;
                ctrl.sr2Imm = ctrl.ir[5];
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
                case (opcode)
                    opAdd:   ctrl.aluOp = aluAdd;
                    opAnd:   ctrl.aluOp = aluAnd;
                    default: ctrl.aluOp = aluNot;
                endcase
            end
            sBr:
            begin
                ctrl.offsetSel = 1'b1;
                ctrl.pcSel     = 1'b1;
                ctrl.ldPc      = ctrl.ben; // not taken, PC already points on
            end
            sLdrAddr, sStrAddr:
            begin
                ctrl.busSrc = busMarmux; // base + offset6, aluOp stays pass
                ctrl.ldMar  = 1'b1;
            end
            sLdrWb:
            begin
                ctrl.busSrc = busMdr;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            sStrData:
            begin
                ctrl.busSrc = busAlu; // SR via pass
                ctrl.ldMdr  = 1'b1;
            end
            sStrWrite:
            begin
                ctrl.memReq = 1'b1;
                ctrl.memWe  = 1'b1;
            end
            default: ;
        endcase
    end

    assign halted = (state == sHalt);

    // MDR never captures memory data without a granted read just before
    mdrAfterRead: assert property (@(posedge Clk) disable iff (!rstN)
        (ctrl.ldMdr && ctrl.mdrSel) |-> $past(ctrl.memReq && !ctrl.memWe && gnt));

endmodule

// File: logic/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic             Clk,
    input  logic             rstN,
    memIf.memory             core,
    input  logic             hostReq,
    input  logic             hostWe,
    input  slcPkg::memAddr_t hostAddr,
    input  slcPkg::word_t    hostWrData,
    output logic             hostGnt,
    output slcPkg::word_t    hostRdData,
    output logic             hostRdValid
);
    import slcPkg::*;

    word_t    mem [memDepth];
    word_t    rdData;
    memAddr_t addr;
    word_t    wdata;
    logic     coreGnt, we, access;

    // core has fixed priority, host only gets idle cycles
    assign coreGnt = core.req;
    assign hostGnt = hostReq && !core.req;
    assign access  = coreGnt || hostGnt;

    // the winner drives the single port
    assign addr  = coreGnt ? core.addr  : hostAddr;
    assign we    = coreGnt ? core.we    : hostWe;
    assign wdata = coreGnt ? core.wdata : hostWrData;

    always_ff @(posedge Clk)
    begin
        if (access && we)
            mem[addr] <= wdata;
        else if (access)
            rdData <= mem[addr]; // registered read, one cycle
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            hostRdValid <= 1'b0;
        else
            hostRdValid <= hostGnt && !hostWe;
    end

    assign core.gnt    = coreGnt;
    assign core.rdata  = rdData; // shared read register
    assign hostRdData  = rdData;

    oneGrant: assert property (@(posedge Clk) disable iff (!rstN)
        !(coreGnt && hostGnt));

endmodule

// File: logic/slcTop.sv
`timescale 1ns/1ps

module slcTop (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             run,
    input  logic             hostReq,
    input  logic             hostWe,
    input  slcPkg::memAddr_t hostAddr,
    input  slcPkg::word_t    hostWrData,
    output logic             hostGnt,
    output slcPkg::word_t    hostRdData,
    output logic             hostRdValid,
    output slcPkg::word_t    pcOut,
    output slcPkg::word_t    irOut,
    output logic             halted
);

    ctrlIf ctrlBus ();  // FSM <-> datapath
    memIf  memBus ();   // core memory port

    datapath datapath_i (
        .Clk   (Clk),
        .rstN  (rstN),
        .ctrl  (ctrlBus.datapath),
        .mem   (memBus.datapath),
        .pcOut (pcOut),
        .irOut (irOut)
    );

    controlFsm controlFsm_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .run    (run),
        .ctrl   (ctrlBus.controller),
        .gnt    (memBus.gnt),   // FSM waits on the core grant
        .halted (halted)
    );

    memSubsystem memSubsystem_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .core        (memBus.memory),
        .hostReq     (hostReq),
        .hostWe      (hostWe),
        .hostAddr    (hostAddr),
        .hostWrData  (hostWrData),
        .hostGnt     (hostGnt),
        .hostRdData  (hostRdData),
        .hostRdValid (hostRdValid)
    );

endmodule

// File: dv/slcTb.sv
`timescale 1ns/1ps

module slcTb;
    import slcPkg::*;

    localparam int    runLimit  = 3000;     // cycles allowed for one program
    localparam int    waitLimit = 50;       // cycles allowed for one host handshake
    localparam word_t haltWord  = 16'hF025; // TRAP x25

    logic     Clk;
    logic     rstN;
    logic     run;
    logic     hostReq;
    logic     hostWe;
    memAddr_t hostAddr;
    word_t    hostWrData;
    logic     hostGnt;
    word_t    hostRdData;
    logic     hostRdValid;
    word_t    pcOut;
    word_t    irOut;
    logic     halted;

    int          errors;
    int unsigned cycle;
    logic [31:0] rngState;
    word_t       progWords[$]; // copy of the loaded program, for reads during a run
    memAddr_t    expAddrs[$];
    word_t       expWords[$];

    slcTop slcTop_i (
        .Clk(Clk), .rstN(rstN), .run(run),
        .hostReq(hostReq), .hostWe(hostWe), .hostAddr(hostAddr), .hostWrData(hostWrData),
        .hostGnt(hostGnt), .hostRdData(hostRdData), .hostRdValid(hostRdValid),
        .pcOut(pcOut), .irOut(irOut), .halted(halted)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk; // 100 ns period
    end

    always @(posedge Clk)
    begin
        cycle <= cycle + 1;
    end

    // xorshift32 step
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic void checkWord(input string name, input word_t exp, input word_t act);
        assert (act === exp)
        else
        begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endfunction

    function automatic void reportTimeout(input string what);
        $display("timeout: %s", what);
        errors++;
    endfunction

    function automatic void checkAfterReset(input string name);
        checkWord({name, " halted"}, 16'd0, {15'd0, halted});
        checkWord({name, " hostGnt"}, 16'd0, {15'd0, hostGnt});
        checkWord({name, " hostRdValid"}, 16'd0, {15'd0, hostRdValid});
        checkWord({name, " pcOut"}, pcReset, pcOut);
    endfunction

    task automatic applyReset();
        @(negedge Clk);
        rstN    = 1'b0;
        run     = 1'b0;
        hostReq = 1'b0;
        hostWe  = 1'b0;
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
    endtask

    // drive at the falling edge, grant is sampled just after it settles
    task automatic waitGrant(input string what);
        int waited;
        waited = 0;
        #1;
        while (!hostGnt && waited < waitLimit)
        begin
            @(negedge Clk);
            #1;
            waited++;
        end
        if (!hostGnt)
            reportTimeout({"no hostGnt for ", what});
    endtask

    task automatic hostWrite(input memAddr_t addr, input word_t data);
        @(negedge Clk);
        hostReq    = 1'b1;
        hostWe     = 1'b1;
        hostAddr   = addr;
        hostWrData = data;
        waitGrant($sformatf("write to %h", addr));
        @(negedge Clk); // written on the grant edge
        hostReq = 1'b0;
        hostWe  = 1'b0;
    endtask

    task automatic hostRead(input memAddr_t addr, output word_t data);
        int lag;
        lag  = 0;
        data = 'x;
        @(negedge Clk);
        hostReq  = 1'b1;
        hostWe   = 1'b0;
        hostAddr = addr;
        waitGrant($sformatf("read of %h", addr));
        @(negedge Clk);
        hostReq = 1'b0;
        while (!hostRdValid && lag < waitLimit)
        begin
            @(negedge Clk);
            lag++;
        end
        if (!hostRdValid)
            reportTimeout($sformatf("no hostRdValid for read of %h", addr));
        else
        begin
            checkWord("hostRdValid delay after grant", 16'd0, word_t'(lag)); // same cycle
            data = hostRdData;
        end
    endtask

    // host keeps reading program words while the core runs
    task automatic runProgram(input string name);
        int unsigned start;
        int          idx;
        int          reads;
        word_t       got;
        reads = 0;
        @(negedge Clk);
        run = 1'b1;
        @(negedge Clk);
        run   = 1'b0;
        start = cycle;
        while (!halted && cycle - start < runLimit)
        begin
            idx = int'(nextRand() % progWords.size());
            hostRead(memAddr_t'(idx), got);
            checkWord($sformatf("%s host read of %h during run", name, idx), progWords[idx], got);
            reads++;
        end
        if (!halted)
            reportTimeout($sformatf("%s did not halt within %0d cycles", name, runLimit));
        else if (reads == 0)
        begin
            $display("no host read was issued while %s was running", name);
            errors++;
        end
    endtask

    initial
    begin
        int       fd;
        int       tests;
        string    line;
        string    kw;
        string    testName;
        word_t    w;
        word_t    got;
        memAddr_t a;
        memAddr_t progAddr;
        errors     = 0;
        tests      = 0;
        cycle      = 0;
        rngState   = 32'd31;
        rstN       = 1'b0;
        run        = 1'b0;
        hostReq    = 1'b0;
        hostWe     = 1'b0;
        hostAddr   = '0;
        hostWrData = '0;
        progAddr   = '0;
        testName   = "none";

        applyReset();
        checkAfterReset("reset");

        // idle core, host owns the memory
        for (int i = 0; i < 12; i++)
        begin
            a = memAddr_t'(nextRand());
            w = word_t'(nextRand() >> 8);
            hostWrite(a, w);
            hostRead(a, got);
            checkWord($sformatf("idle host access %h", a), w, got);
        end

        fd = $fopen("dv/slcPatterns.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open dv/slcPatterns.txt");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if ($sscanf(line, "%s", kw) != 1 || kw[0] == "#")
                    continue; // blank or comment
                if (kw == "test")
                begin
                    void'($sscanf(line, "%s %s", kw, testName));
                    applyReset();
                    checkAfterReset({testName, " reset"});
                    progAddr = '0;
                    progWords.delete();
                    expAddrs.delete();
                    expWords.delete();
                    tests++;
                end
                else if (kw == "prog")
                begin
                    void'($sscanf(line, "%s %h", kw, w));
                    hostWrite(progAddr, w);
                    progWords.push_back(w);
                    progAddr++;
                end
                else if (kw == "data")
                begin
                    void'($sscanf(line, "%s %h %h", kw, a, w));
                    hostWrite(a, w);
                end
                else if (kw == "expect")
                begin
                    void'($sscanf(line, "%s %h %h", kw, a, w));
                    expAddrs.push_back(a);
                    expWords.push_back(w);
                end
                else if (kw == "pc")
                begin
                    void'($sscanf(line, "%s %h", kw, w));
                    runProgram(testName);
                    checkWord({testName, " final pc"}, w, pcOut);
                    checkWord({testName, " ir at halt"}, haltWord, irOut);
                    foreach (expAddrs[k])
                    begin
                        hostRead(expAddrs[k], got);
                        checkWord($sformatf("%s mem[%h]", testName, expAddrs[k]),
                                  expWords[k], got);
                    end
                end
                else
                begin
                    $display("unknown record '%s' in the pattern file", kw);
                    errors++;
                end
            end
            $fclose(fd);
            if (tests == 0)
            begin
                $display("the pattern file holds no test");
                errors++;
            end
        end

        $display("%0d tests from file, %0d errors", tests, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: dv/slcPatterns.txt
# test <name> resets the core; prog <hex word> loads from address 00 upward
# data <addr> <word> preloads memory; expect <addr> <word> checked after halt; pc <final pc> runs
test aluOps
prog 5FE0  # and r7, r7, #0
prog 1FF0  # add r7, r7, #-16 -> base xfff0
prog 5260  # and r1, r1, #0
prog 1267  # add r1, r1, #7
prog 54A0  # and r2, r2, #0
prog 14BD  # add r2, r2, #-3
prog 1642  # add r3, r1, r2
prog 5842  # and r4, r1, r2
prog 9A7F  # not r5, r1
prog 1CB0  # add r6, r2, #-16
prog 5066  # and r0, r1, #6
prog 77C0  # str r3, r7, #0
prog 79C1  # str r4, r7, #1
prog 7BC2  # str r5, r7, #2
prog 7DC3  # str r6, r7, #3
prog 71C4  # str r0, r7, #4
prog F025  # halt at x10
expect F0 0004
expect F1 0005
expect F2 FFF8
expect F3 FFED
expect F4 0006
pc 0011
test loadStore
data E0 1234
data E1 8001
prog 5FE0  # and r7, r7, #0
prog 1FF0  # add r7, r7, #-16
prog 1FF0  # add r7, r7, #-16 -> base xffe0
prog 63C0  # ldr r1, r7, #0
prog 65C1  # ldr r2, r7, #1
prog 1642  # add r3, r1, r2
prog 1861  # add r4, r1, #1
prog 77D0  # str r3, r7, #16
prog 79FF  # str r4, r7, #-1
prog F025  # halt at x09
expect F0 9235
expect DF 1235
expect E0 1234
pc 000A
test branchLoop
prog 5FE0  # and r7, r7, #0
prog 1FF0  # add r7, r7, #-16
prog 5260  # and r1, r1, #0
prog 1265  # add r1, r1, #5, loop count
prog 54A0  # and r2, r2, #0
prog 14A1  # loop: add r2, r2, #1
prog 127F  # add r1, r1, #-1
prog 03FD  # brp loop
prog 0401  # brz skips the next word
prog 14AF  # add r2, r2, #15, never runs
prog 75C5  # str r2, r7, #5
prog 0801  # brn not taken
prog F025  # halt at x0c
prog F025  # reached only by a wrong branch
expect F5 0005
pc 000D

// File: slcTop.f
logic/slcPkg.sv
logic/ctrlIf.sv
logic/memIf.sv
logic/pcUnit.sv
logic/marMdr.sv
logic/regFileAlu.sv
logic/datapath.sv
logic/controlFsm.sv
logic/memSubsystem.sv
logic/slcTop.sv
dv/slcTb.sv

// File: Bender.yml
package:
  name: slc

sources:
  - logic/slcPkg.sv
  - logic/ctrlIf.sv
  - logic/memIf.sv
  - logic/pcUnit.sv
  - logic/marMdr.sv
  - logic/regFileAlu.sv
  - logic/datapath.sv
  - logic/controlFsm.sv
  - logic/memSubsystem.sv
  - logic/slcTop.sv
  - target: simulation
    files:
      - dv/slcTb.sv
